// ==== bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// --------------------
// table geometry
// --------------------
`define BP_IDX_W    6               // pc[7:2].
`define BP_ENTRIES  64
`define BP_TAG_W    24              // pc[31:8].
`define BP_FETCH_W  4               // slots per fetch block.

// --------------------
// two-bit counter encodings
// --------------------
`define BP_CTR_W    2
`define BP_CTR_MAX  2'd3            // strongly taken.
`define BP_CTR_INIT 2'd1            // weakly not taken.
`define BP_CTR_JIRL 2'd2            // weakly taken.

`define BP_RESET_PC 32'h1c00_0000

`endif

// ==== bp_pkg.sv ====
package bp_pkg;

    // --------------------
    // lookup side
    // --------------------

    // one slot of the fetch block, as seen by the PC generator.
    typedef struct packed {
        logic        hit;       // entry occupied and tag equal.
        logic        taken;     // counter msb.
        logic [31:0] target;
    } slot_pred_t;

    // --------------------
    // training side
    // --------------------

    // resolved branch coming back from the reorder buffer.
    typedef struct packed {
        logic        valid;     // is-branch strobe.
        logic        is_jirl;
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;
    } rob_update_t;

    // one of the four predecoder BTB writes per cycle.
    typedef struct packed {
        logic        valid;     // is-branch strobe.
        logic        no_write;  // jirl target unknown here.
        logic [31:0] pc;
        logic [31:0] target;
    } pd_write_t;

    // --------------------
    // back-end flush
    // --------------------

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

// ==== pht_table.sv ====
`include "bp_config.svh"

module pht_table import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            slot_pc [`BP_FETCH_W],
    input  rob_update_t            rob_update,
    output logic [`BP_FETCH_W-1:0] taken
);

    logic [`BP_CTR_W-1:0] ctr [`BP_ENTRIES];
    logic [`BP_IDX_W-1:0] rob_idx;
    logic [`BP_CTR_W-1:0] rob_ctr;

    assign rob_idx = rob_update.pc[`BP_IDX_W+1:2];
    assign rob_ctr = ctr[rob_idx];

    // --------------------
    // lookup
    // --------------------

    always_comb begin
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            taken[i] = ctr[slot_pc[i][`BP_IDX_W+1:2]][`BP_CTR_W-1]; // msb only.
        end
    end

    // --------------------
    // training
    // --------------------

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                ctr[i] <= `BP_CTR_INIT;
            end
        end else if (rob_update.valid) begin
            if (rob_update.is_jirl) begin
                ctr[rob_idx] <= `BP_CTR_JIRL;           // jirl forces weakly taken.
            end else if (rob_update.taken) begin
                if (rob_ctr != `BP_CTR_MAX) begin
                    ctr[rob_idx] <= rob_ctr + 1'b1;
                end
            end else begin
                if (rob_ctr != '0) begin
                    ctr[rob_idx] <= rob_ctr - 1'b1;
                end
            end
        end
    end

endmodule

// ==== btb_table.sv ====
`include "bp_config.svh"

module btb_table import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            slot_pc  [`BP_FETCH_W],
    input  rob_update_t            rob_update,
    input  pd_write_t              pd_write [`BP_FETCH_W],
    output logic [`BP_FETCH_W-1:0] hit,
    output logic [31:0]            target   [`BP_FETCH_W]
);

    logic [`BP_ENTRIES-1:0] occupied;
    logic [`BP_TAG_W-1:0]   tag_mem [`BP_ENTRIES];
    logic [31:0]            tgt_mem [`BP_ENTRIES];

    logic                   rob_we;
    logic [`BP_IDX_W-1:0]   rob_idx;
    logic [`BP_FETCH_W-1:0] pd_we;
    logic [`BP_IDX_W-1:0]   pd_idx [`BP_FETCH_W];

    // --------------------
    // write decode
    // --------------------

    assign rob_we  = rob_update.valid && rob_update.is_jirl;
    assign rob_idx = rob_update.pc[`BP_IDX_W+1:2];

    always_comb begin
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            pd_we[i]  = pd_write[i].valid && !pd_write[i].no_write;
            pd_idx[i] = pd_write[i].pc[`BP_IDX_W+1:2];
        end
    end

    // --------------------
    // lookup
    // --------------------

    always_comb begin
        logic [`BP_IDX_W-1:0] idx;
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            idx       = slot_pc[i][`BP_IDX_W+1:2];
            hit[i]    = occupied[idx] && (tag_mem[idx] == slot_pc[i][31 -: `BP_TAG_W]);
            target[i] = tgt_mem[idx];
        end
    end

    // --------------------
    // update
    // --------------------

    // later assignments win, so predecoder beats rob and high slot beats low.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            occupied <= '0;
        end else begin
            if (rob_we) begin
                occupied[rob_idx] <= 1'b1;
            end
            for (int i = 0; i < `BP_FETCH_W; i++) begin
                if (pd_we[i]) begin
                    occupied[pd_idx[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rob_we) begin
            tag_mem[rob_idx] <= rob_update.pc[31 -: `BP_TAG_W];
            tgt_mem[rob_idx] <= rob_update.target;
        end
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            if (pd_we[i]) begin
                tag_mem[pd_idx[i]] <= pd_write[i].pc[31 -: `BP_TAG_W];
                tgt_mem[pd_idx[i]] <= pd_write[i].target;
            end
        end
    end

endmodule

// ==== fetch_pc_gen.sv ====
`include "bp_config.svh"

module fetch_pc_gen import bp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  redirect_t   redirect,
    input  slot_pred_t  slot_pred [`BP_FETCH_W],
    output logic [31:0] fetch_pc,
    output logic [31:0] slot_pc   [`BP_FETCH_W],
    output logic [31:0] next_pc
);

    localparam int OFF_W   = $clog2(`BP_FETCH_W);
    localparam int BLK_LSB = OFF_W + 2;

    logic [31:0]            block_base;
    logic [OFF_W-1:0]       fetch_off;
    logic [`BP_FETCH_W-1:0] slot_valid;
    logic [`BP_FETCH_W-1:0] slot_take;

    // --------------------
    // slot addresses
    // --------------------

    assign block_base = {fetch_pc[31:BLK_LSB], {BLK_LSB{1'b0}}};
    assign fetch_off  = fetch_pc[BLK_LSB-1:2];

    always_comb begin
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            slot_pc[i]    = block_base + 32'(4 * i);
            slot_valid[i] = (i >= int'(fetch_off)); // skip slots before entry point.
            slot_take[i]  = slot_valid[i] && slot_pred[i].hit && slot_pred[i].taken;
        end
    end

    // --------------------
    // next pc select
    // --------------------

    always_comb begin
        next_pc = block_base + 32'(4 * `BP_FETCH_W);    // sequential block.
        for (int i = `BP_FETCH_W - 1; i >= 0; i--) begin
            if (slot_take[i]) begin
                next_pc = slot_pred[i].target;          // lowest slot ends up winning.
            end
        end
        if (redirect.valid) begin
            next_pc = redirect.pc;
        end
    end

    // flush loads even while stalled.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fetch_pc <= `BP_RESET_PC;
        end else if (redirect.valid || !stall) begin
            fetch_pc <= next_pc;
        end
    end

endmodule

// ==== fetch_predictor.sv ====
`include "bp_config.svh"

module fetch_predictor import bp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  redirect_t   redirect,
    input  rob_update_t rob_update,
    input  pd_write_t   pd_write  [`BP_FETCH_W],
    output logic [31:0] fetch_pc,
    output logic [31:0] slot_pc   [`BP_FETCH_W],
    output slot_pred_t  slot_pred [`BP_FETCH_W],
    output logic [31:0] next_pc
);

    logic [`BP_FETCH_W-1:0] pht_taken;
    logic [`BP_FETCH_W-1:0] btb_hit;
    logic [31:0]            btb_target [`BP_FETCH_W];

    fetch_pc_gen u_pc_gen (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .redirect  (redirect),
        .slot_pred (slot_pred),
        .fetch_pc  (fetch_pc),
        .slot_pc   (slot_pc),
        .next_pc   (next_pc)
    );

    pht_table u_pht (
        .clk        (clk),
        .rst        (rst),
        .slot_pc    (slot_pc),
        .rob_update (rob_update),
        .taken      (pht_taken)
    );

    btb_table u_btb (
        .clk        (clk),
        .rst        (rst),
        .slot_pc    (slot_pc),
        .rob_update (rob_update),
        .pd_write   (pd_write),
        .hit        (btb_hit),
        .target     (btb_target)
    );

    // --------------------
    // merge table outputs per slot
    // --------------------

    always_comb begin
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            slot_pred[i].hit    = btb_hit[i];
            slot_pred[i].taken  = pht_taken[i];
            slot_pred[i].target = btb_target[i];
        end
    end

endmodule

// ==== fetch_predictor_assertions.sv ====
module fetch_predictor_assertions import bp_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input redirect_t   redirect,
    input logic [31:0] fetch_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors;

    redirect_lands: assert property (@(posedge clk) disable iff (!rst)
        redirect.valid |=> fetch_pc == $past(redirect.pc))
    else begin
        $error("redirect target did not reach fetch_pc one cycle later");
        assert_errors++;
    end

    stall_holds: assert property (@(posedge clk) disable iff (!rst)
        stall && !redirect.valid |=> fetch_pc == $past(fetch_pc))
    else begin
        $error("fetch_pc moved while stalled without a redirect");
        assert_errors++;
    end

    word_aligned: assert property (@(posedge clk) disable iff (!rst)
        fetch_pc[1:0] == 2'b00)
    else begin
        $error("fetch_pc is not word aligned");
        assert_errors++;
    end

endmodule

bind fetch_predictor fetch_predictor_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .redirect (redirect),
    .fetch_pc (fetch_pc)
);

// ==== fetch_predictor_checker.sv ====
`include "bp_config.svh"

module fetch_predictor_checker import bp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  redirect_t   redirect,
    input  rob_update_t rob_update,
    input  pd_write_t   pd_write  [`BP_FETCH_W],
    input  logic [31:0] fetch_pc,
    input  logic [31:0] slot_pc   [`BP_FETCH_W],
    input  slot_pred_t  slot_pred [`BP_FETCH_W],
    input  logic [31:0] next_pc,
    output int          check_count,
    output int          error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // reference state
    // --------------------
    logic [1:0]  ref_ctr [`BP_ENTRIES];
    logic        ref_occ [`BP_ENTRIES];
    logic [23:0] ref_tag [`BP_ENTRIES];
    logic [31:0] ref_tgt [`BP_ENTRIES];
    logic [31:0] ref_fetch;
    logic [31:0] ref_next;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic write_btb(input logic [31:0] pc, input logic [31:0] target);
        ref_occ[pc[7:2]] = 1'b1;
        ref_tag[pc[7:2]] = pc[31:8];
        ref_tgt[pc[7:2]] = target;
    endtask

    task automatic check_outputs();
        logic [31:0] base;
        logic [31:0] pc;
        logic        hit;
        logic        found;
        base     = {ref_fetch[31:4], 4'h0};
        ref_next = base + 32'd16;           // fall through to next block.
        found    = 1'b0;
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            pc  = base + 32'(4 * i);
            hit = ref_occ[pc[7:2]] && (ref_tag[pc[7:2]] == pc[31:8]);
            compare_value($sformatf("slot_pc[%0d]", i), pc, slot_pc[i]);
            compare_value($sformatf("slot_pred[%0d].hit", i), 32'(hit), 32'(slot_pred[i].hit));
            compare_value($sformatf("slot_pred[%0d].taken", i), 32'(ref_ctr[pc[7:2]][1]),
                          32'(slot_pred[i].taken));
            if (hit) begin
                compare_value($sformatf("slot_pred[%0d].target", i), ref_tgt[pc[7:2]],
                              slot_pred[i].target);
                if (!found && ref_ctr[pc[7:2]][1] && i >= int'(ref_fetch[3:2])) begin
                    ref_next = ref_tgt[pc[7:2]];
                    found    = 1'b1;
                end
            end
        end
        if (redirect.valid) begin
            ref_next = redirect.pc;
        end
        compare_value("fetch_pc", ref_fetch, fetch_pc);
        compare_value("next_pc", ref_next, next_pc);
    endtask

    task automatic update_model();
        logic [5:0] idx;
        idx = rob_update.pc[7:2];
        if (rob_update.valid && rob_update.is_jirl) begin
            ref_ctr[idx] = 2'd2;
            write_btb(rob_update.pc, rob_update.target);
        end else if (rob_update.valid && rob_update.taken && ref_ctr[idx] != 2'd3) begin
            ref_ctr[idx] = ref_ctr[idx] + 2'd1;
        end else if (rob_update.valid && !rob_update.taken && ref_ctr[idx] != 2'd0) begin
            ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        end
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            if (pd_write[i].valid && !pd_write[i].no_write) begin
                write_btb(pd_write[i].pc, pd_write[i].target);  // later slot overwrites.
            end
        end
        if (redirect.valid || !stall) begin
            ref_fetch = ref_next;
        end
    endtask

    // inputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                ref_ctr[i] = 2'd1;
                ref_occ[i] = 1'b0;
            end
            ref_fetch   = 32'h1c00_0000;
            check_count = 0;
            error_count = 0;
        end else begin
            check_outputs();
            update_model();
        end
    end

endmodule

// ==== fetch_predictor_tb.sv ====
`include "bp_config.svh"

module fetch_predictor_tb import bp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CASES    = 64;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        stall;
    redirect_t   redirect;
    rob_update_t rob_update;
    pd_write_t   pd_write  [`BP_FETCH_W];
    logic [31:0] fetch_pc;
    logic [31:0] slot_pc   [`BP_FETCH_W];
    slot_pred_t  slot_pred [`BP_FETCH_W];
    logic [31:0] next_pc;
    int          check_count;
    int          error_count;

    // --------------------
    // case table
    // --------------------
    logic        case_stall [MAX_CASES];
    redirect_t   case_redir [MAX_CASES];
    rob_update_t case_rob   [MAX_CASES];
    pd_write_t   case_pd    [MAX_CASES][`BP_FETCH_W];
    int          case_rep   [MAX_CASES];
    int          num_cases;
    int          num_repeats;
    int          load_errors;
    logic        cases_loaded;
    logic [31:0] lfsr_state;

    fetch_predictor u_dut (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .rob_update(rob_update), .pd_write(pd_write), .fetch_pc(fetch_pc),
        .slot_pc(slot_pc), .slot_pred(slot_pred), .next_pc(next_pc)
    );

    fetch_predictor_checker u_checker (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .rob_update(rob_update), .pd_write(pd_write), .fetch_pc(fetch_pc),
        .slot_pc(slot_pc), .slot_pred(slot_pred), .next_pc(next_pc),
        .check_count(check_count), .error_count(error_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        int          rep;
        string       line;
        logic        st;
        logic        rv;
        logic [31:0] rpc;
        logic [3:0]  rob_f;
        logic [31:0] rob_pc;
        logic [31:0] rob_tgt;
        logic [3:0]  pd_f   [`BP_FETCH_W];
        logic [31:0] pd_pc  [`BP_FETCH_W];
        logic [31:0] pd_tgt [`BP_FETCH_W];
        fd = $fopen("fetch_predictor_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open fetch_predictor_cases.txt");
            load_errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                            st, rv, rpc, rob_f, rob_pc, rob_tgt,
                            pd_f[0], pd_pc[0], pd_tgt[0], pd_f[1], pd_pc[1], pd_tgt[1],
                            pd_f[2], pd_pc[2], pd_tgt[2], pd_f[3], pd_pc[3], pd_tgt[3], rep);
                if (n != 19 || num_cases == MAX_CASES) begin
                    $display("case line rejected, bad format or table full: %s", line);
                    load_errors++;
                end else begin
                    case_stall[num_cases] = st;
                    case_redir[num_cases] = '{valid: rv, pc: rpc};
                    case_rob[num_cases]   = '{valid: rob_f[2], is_jirl: rob_f[1],
                                              taken: rob_f[0], pc: rob_pc, target: rob_tgt};
                    for (int i = 0; i < `BP_FETCH_W; i++) begin
                        case_pd[num_cases][i] = '{valid: pd_f[i][1], no_write: pd_f[i][0],
                                                  pc: pd_pc[i], target: pd_tgt[i]};
                    end
                    case_rep[num_cases] = rep;
                    num_repeats += rep;
                    num_cases++;
                end
            end
            $fclose(fd);
            if (num_cases == 0) begin
                $display("case file holds no records");
                load_errors++;
            end
        end
    endtask

    task automatic drive_case(input int k);
        stall      <= case_stall[k];
        redirect   <= case_redir[k];
        rob_update <= case_rob[k];
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            pd_write[i] <= case_pd[k][i];
        end
    endtask

    task automatic drive_idle(input logic stall_bit);
        stall      <= stall_bit;
        redirect   <= '0;
        rob_update <= '0;
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            pd_write[i] <= '0;
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        assert_errors = u_dut.u_assertions.assert_errors;
        $display("checks %0d, mismatches %0d, assertion failures %0d, case file errors %0d",
                 check_count, error_count, assert_errors, load_errors);
        if (error_count + assert_errors + load_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst          = 1'b0;
        stall        = 1'b0;
        redirect     = '0;
        rob_update   = '0;
        for (int i = 0; i < `BP_FETCH_W; i++) begin
            pd_write[i] = '0;
        end
        lfsr_state   = 32'hd92e;
        num_cases    = 0;
        num_repeats  = 0;
        load_errors  = 0;
        cases_loaded = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        if (load_errors == 0) begin
            for (int k = 0; k < num_cases; k++) begin
                @(posedge clk);
                drive_case(k);
                for (int r = 0; r < case_rep[k]; r++) begin
                    @(posedge clk);
                    lfsr_state = lfsr_next(lfsr_state);     // one step per stall bit.
                    drive_idle(lfsr_state[0]);
                end
            end
        end
        repeat (2) begin
            @(posedge clk);
            drive_idle(1'b0);
        end
        @(posedge clk);
        report_and_finish();
    end

    // watchdog budget covers reset and the drain cycles.
    initial begin
        wait (cases_loaded);
        repeat (num_cases + num_repeats + 20) @(posedge clk);
        $display("timeout after %0d cycles, stimulus never finished",
                 num_cases + num_repeats + 20);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== fetch_predictor.f ====
+incdir+.
bp_pkg.sv
pht_table.sv
btb_table.sv
fetch_pc_gen.sv
fetch_predictor.sv
fetch_predictor_assertions.sv
fetch_predictor_checker.sv
fetch_predictor_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_predictor

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - pht_table.sv
      - btb_table.sv
      - fetch_pc_gen.sv
      - fetch_predictor.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetch_predictor_assertions.sv
      - fetch_predictor_checker.sv
      - fetch_predictor_tb.sv

// ==== fetch_predictor_cases.txt ====
# stall redir_v redir_pc rob_f rob_pc rob_tgt, rob_f bits are valid is_jirl taken
# then pd_f pc tgt for slots 0 to 3, pd_f bits are valid no_write, last column is repeats
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  3
# park on block 1c000100 and fill the btb
0 1 1c000100 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 0 0 0  2 1c000104 1c000800  3 1c000108 1c000900  0 0 0  0 0 0  0
1 0 0 0 0 0  0 0 0  2 2c000108 1c000c00  2 1c00010c 1c000a00  2 1c00010c 1c000b00  0
1 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
# counter of 1c000104 up to 3 and down to 0
1 0 0 5 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 5 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 5 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 4 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 4 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 4 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 4 1c000104 0  0 0 0  0 0 0  0 0 0  0 0 0  0
# jirl on slot 3, then release the stall
1 0 0 6 1c00010c 1c000d00  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
# mid-block redirect under stall skips slot 1
1 1 1c000108 6 1c000104 1c000e00  0 0 0  0 0 0  0 0 0  0 0 0  0
1 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 1 1c000100 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
# predecoder beats rob on index 0
1 1 1c000200 6 1c000200 1c0003f0  2 1c000200 1c000300  2 1c000204 1c000310  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  6
0 1 1c000040 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  4
0 0 0 0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0
